// File: source/wb_core_pkg.sv
/*
  Core-wide constants for the writeback end. FLEN must equal XLEN, since load data
  and ALU results share one datapath into either register file.
*/
`default_nettype none

package wb_core_pkg;

  // Data width of the integer datapath and of the load/store path
  localparam int unsigned XLEN = 32;

  // Single precision only, so an FP register is as wide as an integer register
  localparam int unsigned FLEN = 32;

  // Register file geometry, shared by the integer and the FP file
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 32;

  // 1 gives the registered writeback stage
  // 0 gives a combinational passthrough with ready tied high
  localparam bit WB_STAGE_EN = 1'b1;

  // Kind of instruction handed to writeback
  // Only LOAD and STORE wait for the LSU, everything else retires in one cycle
  typedef enum logic [1:0] {
    OTHER = 2'b00,
    LOAD  = 2'b01,
    STORE = 2'b10
  } instr_type_e;

endpackage

`default_nettype wire

// File: source/wb_lsu.sv
/*
  One request at a time, answered exactly LSU_LATENCY cycles later. Word accesses only.
  A misaligned or out-of-range address gives an error and touches neither memory nor RF.
*/
`default_nettype none

module wb_lsu (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,

  input  wire logic                          req_i,
  input  wire logic                          we_i,
  input  wire logic [wb_core_pkg::XLEN-1:0] addr_i,
  input  wire logic [wb_core_pkg::XLEN-1:0] wdata_i,

  output logic                               resp_valid_o,
  output logic                               resp_err_o,
  output logic      [wb_core_pkg::XLEN-1:0] rdata_o,
  output logic                               rf_we_o
);

  logic [wb_core_pkg::XLEN-1:0]        mem_q [wb_mem_pkg::MEM_WORDS];
  logic [wb_mem_pkg::LSU_CNT_W-1:0]    cnt_q;
  logic                                we_q;
  logic [wb_core_pkg::XLEN-1:0]        addr_q;
  logic [wb_core_pkg::XLEN-1:0]        wdata_q;
  logic [wb_mem_pkg::MEM_ADDR_W-1:0]   word_idx;
  logic                                misaligned;
  logic                                out_of_range;
  logic                                addr_bad;

  // Countdown is loaded on a request and the response fires as it passes 1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (req_i) begin
      cnt_q <= wb_mem_pkg::LSU_CNT_W'(wb_mem_pkg::LSU_LATENCY);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Request payload is held until the response
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
  end

  assign resp_valid_o = (cnt_q == wb_mem_pkg::LSU_CNT_W'(1));

  // Byte address bits 1:0 must be zero and everything above the word index must be clear
  assign word_idx     = addr_q[wb_mem_pkg::MEM_ADDR_W+1:2];
  assign misaligned   = (addr_q[1:0] != 2'b00);
  assign out_of_range = (addr_q[wb_core_pkg::XLEN-1:wb_mem_pkg::MEM_ADDR_W+2] != '0);
  assign addr_bad     = misaligned | out_of_range;

  assign resp_err_o = resp_valid_o & addr_bad;

  // Only a clean load asks writeback to update a register
  assign rf_we_o = resp_valid_o & ~we_q & ~addr_bad;
  assign rdata_o = mem_q[word_idx];

  // Store data lands at the response edge, together with any load writeback
  always_ff @(posedge clk_i) begin
    if (resp_valid_o && we_q && !addr_bad) begin
      mem_q[word_idx] <= wdata_q;
    end
  end

endmodule

`default_nettype wire

// File: source/wb_mem_pkg.sv
/*
  Data memory geometry and LSU timing. LSU_LATENCY must be at least 1.
*/
`default_nettype none

package wb_mem_pkg;

  // Word-addressed data memory, byte addresses run from 0 to MEM_WORDS*4-1
  localparam int unsigned MEM_WORDS  = 64;
  localparam int unsigned MEM_ADDR_W = 6;

  // Cycles from the request edge to the response edge
  localparam int unsigned LSU_LATENCY = 2;

  // Width of the countdown that times a response
  localparam int unsigned LSU_CNT_W = $clog2(LSU_LATENCY + 1);

endpackage

`default_nettype wire

// File: source/wb_reg_file.sv
/*
  Two combinational read ports and one write port, no reset.
  With HAS_ZERO_REG set, entry 0 reads zero and drops writes.
*/
`default_nettype none

module wb_reg_file #(
  parameter bit HAS_ZERO_REG = 1'b0
) (
  input  wire logic                                clk_i,

  input  wire logic [wb_core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  wire logic [wb_core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic      [wb_core_pkg::XLEN-1:0]       rdata_a_o,
  output logic      [wb_core_pkg::XLEN-1:0]       rdata_b_o,

  input  wire logic [wb_core_pkg::REG_ADDR_W-1:0] waddr_i,
  input  wire logic [wb_core_pkg::XLEN-1:0]       wdata_i,
  input  wire logic                                we_i
);

  logic [wb_core_pkg::XLEN-1:0] regs_q [wb_core_pkg::NUM_REGS];
  logic                         wr_blocked;
  logic                         rd_a_zero;
  logic                         rd_b_zero;

  // A write to the hardwired zero entry is dropped
  assign wr_blocked = HAS_ZERO_REG && (waddr_i == '0);

  always_ff @(posedge clk_i) begin
    if (we_i && !wr_blocked) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Entry 0 is never written in the integer file, so its read is forced to zero here
  assign rd_a_zero = HAS_ZERO_REG && (raddr_a_i == '0);
  assign rd_b_zero = HAS_ZERO_REG && (raddr_b_i == '0);

  assign rdata_a_o = rd_a_zero ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = rd_b_zero ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// File: source/wb_stage.sv
/*
  Holds one instruction and retires it. OTHER finishes one cycle after acceptance,
  LOAD and STORE wait for the LSU response. The FP file shares the integer destination address.
*/
`default_nettype none

module wb_stage (
  input  wire logic                                clk_i,
  input  wire logic                                rst_ni,

  // Issue side
  input  wire logic                                en_wb_i,
  input  wire wb_core_pkg::instr_type_e            instr_type_i,
  input  wire logic [wb_core_pkg::XLEN-1:0]       pc_i,
  input  wire logic                                compressed_i,
  input  wire logic                                perf_count_i,
  input  wire logic [wb_core_pkg::REG_ADDR_W-1:0] rf_waddr_i,
  input  wire logic [wb_core_pkg::XLEN-1:0]       rf_wdata_i,
  input  wire logic                                rf_we_i,
  input  wire logic [wb_core_pkg::FLEN-1:0]       fp_rf_wdata_i,
  input  wire logic                                fp_rf_we_i,
  input  wire logic                                fp_load_i,
  output logic                                     ready_wb_o,

  // LSU side
  output logic                                     lsu_req_o,
  output logic                                     lsu_we_o,
  input  wire logic                                lsu_resp_valid_i,
  input  wire logic                                lsu_resp_err_i,
  input  wire logic [wb_core_pkg::XLEN-1:0]       lsu_rdata_i,
  input  wire logic                                lsu_rf_we_i,

  // Register file write ports
  output logic      [wb_core_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic      [wb_core_pkg::XLEN-1:0]       rf_wdata_o,
  output logic                                     rf_we_o,
  output logic      [wb_core_pkg::REG_ADDR_W-1:0] fp_rf_waddr_o,
  output logic      [wb_core_pkg::FLEN-1:0]       fp_rf_wdata_o,
  output logic                                     fp_rf_we_o,

  // Hazard, forwarding and retire status
  output logic                                     rf_write_wb_o,
  output logic                                     fp_rf_write_wb_o,
  output logic      [wb_core_pkg::XLEN-1:0]       rf_wdata_fwd_o,
  output logic                                     outstanding_load_o,
  output logic                                     outstanding_store_o,
  output logic      [wb_core_pkg::XLEN-1:0]       pc_wb_o,
  output logic                                     instr_done_o,
  output logic                                     perf_instr_ret_o,
  output logic                                     perf_instr_ret_compressed_o
);

  // ALU-side write requests, produced by whichever branch is built
  logic                          alu_we;
  logic [wb_core_pkg::XLEN-1:0] alu_wdata;
  logic                          fp_alu_we;
  logic [wb_core_pkg::FLEN-1:0] fp_alu_wdata;
  // Load data goes to the FP file when this is set
  logic                          load_to_fp;
  logic                          lsu_err_resp;

  assign lsu_err_resp = lsu_resp_valid_i & lsu_resp_err_i;

  if (wb_core_pkg::WB_STAGE_EN) begin : g_wb_stage
    logic                            valid_q;
    logic                            done;
    logic                            accept;
    wb_core_pkg::instr_type_e        type_q;
    logic [wb_core_pkg::XLEN-1:0]   pc_q;
    logic                            compressed_q;
    logic                            count_q;
    logic [wb_core_pkg::REG_ADDR_W-1:0] waddr_q;
    logic [wb_core_pkg::XLEN-1:0]   wdata_q;
    logic                            we_q;
    logic [wb_core_pkg::FLEN-1:0]   fp_wdata_q;
    logic                            fp_we_q;
    logic                            fp_load_q;
    logic                            is_load_q;

    // OTHER is done as soon as it is held, memory ops wait for the response
    assign done       = (type_q == wb_core_pkg::OTHER) | lsu_resp_valid_i;
    assign ready_wb_o = ~valid_q | done;
    assign accept     = en_wb_i & ready_wb_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q <= 1'b0;
      end else begin
        valid_q <= accept | (valid_q & ~done);
      end
    end

    always_ff @(posedge clk_i) begin
      if (accept) begin
        type_q       <= instr_type_i;
        pc_q         <= pc_i;
        compressed_q <= compressed_i;
        count_q      <= perf_count_i;
        waddr_q      <= rf_waddr_i;
        wdata_q      <= rf_wdata_i;
        we_q         <= rf_we_i;
        fp_wdata_q   <= fp_rf_wdata_i;
        fp_we_q      <= fp_rf_we_i;
        fp_load_q    <= fp_load_i;
      end
    end

    // The LSU request leaves in the accepting cycle, so the LSU sees it at the same edge
    assign lsu_req_o = accept & (instr_type_i != wb_core_pkg::OTHER);
    assign lsu_we_o  = instr_type_i == wb_core_pkg::STORE;

    assign alu_we       = valid_q & we_q;
    assign alu_wdata    = wdata_q;
    assign fp_alu_we    = valid_q & fp_we_q;
    assign fp_alu_wdata = fp_wdata_q;
    assign load_to_fp   = fp_load_q;
    assign rf_waddr_o   = waddr_q;

    assign is_load_q           = type_q == wb_core_pkg::LOAD;
    assign outstanding_load_o  = valid_q & is_load_q;
    assign outstanding_store_o = valid_q & (type_q == wb_core_pkg::STORE);

    // A pending load counts as a write to whichever file it is steered to
    assign rf_write_wb_o    = valid_q & (we_q | (is_load_q & ~fp_load_q));
    assign fp_rf_write_wb_o = valid_q & (fp_we_q | (is_load_q & fp_load_q));

    // Load data arrives too late for the forwarding path, so only the held ALU result goes
    assign rf_wdata_fwd_o = wdata_q;
    assign pc_wb_o        = pc_q;
    assign instr_done_o   = valid_q & done;

    // An instruction that faulted in the LSU is not counted as retired
    assign perf_instr_ret_o            = instr_done_o & count_q & ~lsu_err_resp;
    assign perf_instr_ret_compressed_o = perf_instr_ret_o & compressed_q;
  end else begin : g_passthrough
    // Writes go straight through and the issue side never stalls
    assign ready_wb_o   = 1'b1;
    assign lsu_req_o    = en_wb_i & (instr_type_i != wb_core_pkg::OTHER);
    assign lsu_we_o     = instr_type_i == wb_core_pkg::STORE;

    assign alu_we       = en_wb_i & rf_we_i;
    assign alu_wdata    = rf_wdata_i;
    assign fp_alu_we    = en_wb_i & fp_rf_we_i;
    assign fp_alu_wdata = fp_rf_wdata_i;
    // fp_load_i must be held by the issue side until the load responds
    assign load_to_fp   = fp_load_i;
    assign rf_waddr_o   = rf_waddr_i;

    assign outstanding_load_o  = 1'b0;
    assign outstanding_store_o = 1'b0;
    assign rf_write_wb_o       = 1'b0;
    assign fp_rf_write_wb_o    = 1'b0;
    assign rf_wdata_fwd_o      = '0;
    assign pc_wb_o             = '0;
    assign instr_done_o        = 1'b0;

    assign perf_instr_ret_o            = en_wb_i & perf_count_i & ~lsu_err_resp;
    assign perf_instr_ret_compressed_o = perf_instr_ret_o & compressed_i;
  end

  // One source per file per cycle, the ALU write wins the mux when it is active
  assign rf_we_o       = alu_we | (lsu_rf_we_i & ~load_to_fp);
  assign rf_wdata_o    = alu_we ? alu_wdata : lsu_rdata_i;
  assign fp_rf_we_o    = fp_alu_we | (lsu_rf_we_i & load_to_fp);
  assign fp_rf_wdata_o = fp_alu_we ? fp_alu_wdata : lsu_rdata_i;
  assign fp_rf_waddr_o = rf_waddr_o;

endmodule

`default_nettype wire

// File: source/wb_subsystem.sv
/*
  Writeback stage with its LSU and both register files. Register files and data
  memory power up undefined, so software must write before it reads.
*/
`default_nettype none

module wb_subsystem (
  input  wire logic                                clk_i,
  input  wire logic                                rst_ni,

  // Issue side
  input  wire logic                                en_wb_i,
  input  wire wb_core_pkg::instr_type_e            instr_type_i,
  input  wire logic [wb_core_pkg::XLEN-1:0]       pc_i,
  input  wire logic                                compressed_i,
  input  wire logic                                perf_count_i,
  input  wire logic [wb_core_pkg::REG_ADDR_W-1:0] rf_waddr_i,
  input  wire logic [wb_core_pkg::XLEN-1:0]       rf_wdata_i,
  input  wire logic                                rf_we_i,
  input  wire logic [wb_core_pkg::FLEN-1:0]       fp_rf_wdata_i,
  input  wire logic                                fp_rf_we_i,
  input  wire logic                                fp_load_i,
  input  wire logic [wb_core_pkg::XLEN-1:0]       lsu_addr_i,
  input  wire logic [wb_core_pkg::XLEN-1:0]       lsu_wdata_i,

  // Register read ports
  input  wire logic [wb_core_pkg::REG_ADDR_W-1:0] rf_raddr_a_i,
  input  wire logic [wb_core_pkg::REG_ADDR_W-1:0] rf_raddr_b_i,
  input  wire logic [wb_core_pkg::REG_ADDR_W-1:0] fp_raddr_i,
  output logic      [wb_core_pkg::XLEN-1:0]       rf_rdata_a_o,
  output logic      [wb_core_pkg::XLEN-1:0]       rf_rdata_b_o,
  output logic      [wb_core_pkg::FLEN-1:0]       fp_rdata_o,

  // Status
  output logic                                     ready_wb_o,
  output logic                                     instr_done_o,
  output logic      [wb_core_pkg::XLEN-1:0]       pc_wb_o,
  output logic                                     perf_instr_ret_o,
  output logic                                     perf_instr_ret_compressed_o,
  output logic                                     outstanding_load_o,
  output logic                                     outstanding_store_o,
  output logic                                     rf_write_wb_o,
  output logic                                     fp_rf_write_wb_o,
  output logic      [wb_core_pkg::XLEN-1:0]       rf_wdata_fwd_o
);

  logic                                lsu_req;
  logic                                lsu_we;
  logic                                lsu_resp_valid;
  logic                                lsu_resp_err;
  logic [wb_core_pkg::XLEN-1:0]       lsu_rdata;
  logic                                lsu_rf_we;
  logic [wb_core_pkg::REG_ADDR_W-1:0] rf_waddr;
  logic [wb_core_pkg::XLEN-1:0]       rf_wdata;
  logic                                rf_we;
  logic [wb_core_pkg::REG_ADDR_W-1:0] fp_rf_waddr;
  logic [wb_core_pkg::FLEN-1:0]       fp_rf_wdata;
  logic                                fp_rf_we;

  wb_stage u_wb_stage (
    .clk_i, .rst_ni, .en_wb_i, .instr_type_i, .pc_i, .compressed_i, .perf_count_i,
    .rf_waddr_i, .rf_wdata_i, .rf_we_i, .fp_rf_wdata_i, .fp_rf_we_i, .fp_load_i,
    .ready_wb_o,
    .lsu_req_o        (lsu_req),
    .lsu_we_o         (lsu_we),
    .lsu_resp_valid_i (lsu_resp_valid),
    .lsu_resp_err_i   (lsu_resp_err),
    .lsu_rdata_i      (lsu_rdata),
    .lsu_rf_we_i      (lsu_rf_we),
    .rf_waddr_o       (rf_waddr),
    .rf_wdata_o       (rf_wdata),
    .rf_we_o          (rf_we),
    .fp_rf_waddr_o    (fp_rf_waddr),
    .fp_rf_wdata_o    (fp_rf_wdata),
    .fp_rf_we_o       (fp_rf_we),
    .rf_write_wb_o, .fp_rf_write_wb_o, .rf_wdata_fwd_o,
    .outstanding_load_o, .outstanding_store_o, .pc_wb_o, .instr_done_o,
    .perf_instr_ret_o, .perf_instr_ret_compressed_o
  );

  wb_lsu u_lsu (
    .clk_i, .rst_ni,
    .req_i        (lsu_req),
    .we_i         (lsu_we),
    .addr_i       (lsu_addr_i),
    .wdata_i      (lsu_wdata_i),
    .resp_valid_o (lsu_resp_valid),
    .resp_err_o   (lsu_resp_err),
    .rdata_o      (lsu_rdata),
    .rf_we_o      (lsu_rf_we)
  );

  // Integer file keeps x0 at zero
  wb_reg_file #(.HAS_ZERO_REG(1'b1)) u_int_rf (
    .clk_i,
    .raddr_a_i (rf_raddr_a_i),
    .raddr_b_i (rf_raddr_b_i),
    .rdata_a_o (rf_rdata_a_o),
    .rdata_b_o (rf_rdata_b_o),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we)
  );

  // FP file has no zero register, so f0 is an ordinary register
  // Only one FP read port has a consumer, port b stays open
  wb_reg_file #(.HAS_ZERO_REG(1'b0)) u_fp_rf (
    .clk_i,
    .raddr_a_i (fp_raddr_i),
    .raddr_b_i (fp_raddr_i),
    .rdata_a_o (fp_rdata_o),
    .rdata_b_o (),
    .waddr_i   (fp_rf_waddr),
    .wdata_i   (fp_rf_wdata),
    .we_i      (fp_rf_we)
  );

endmodule

`default_nettype wire

// File: tests/tb_wb_subsystem.sv
/*
  Directed testbench for the writeback subsystem. Every register is written before it
  is read, and loads in the mixed run only use words that were stored earlier.
*/
`default_nettype none

module tb_wb_subsystem;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned AW             = wb_core_pkg::REG_ADDR_W;
  localparam int unsigned TIMEOUT_CYCLES = 2000;

  logic                           clk_i = 1'b0;
  logic                           rst_ni;
  logic                           en_wb_i;
  wb_core_pkg::instr_type_e       instr_type_i;
  logic [31:0]                    pc_i;
  logic                           compressed_i;
  logic                           perf_count_i;
  logic [AW-1:0]                  rf_waddr_i;
  logic [31:0]                    rf_wdata_i;
  logic                           rf_we_i;
  logic [31:0]                    fp_rf_wdata_i;
  logic                           fp_rf_we_i;
  logic                           fp_load_i;
  logic [31:0]                    lsu_addr_i;
  logic [31:0]                    lsu_wdata_i;
  logic [AW-1:0]                  rf_raddr_a_i;
  logic [AW-1:0]                  rf_raddr_b_i;
  logic [AW-1:0]                  fp_raddr_i;
  logic [31:0]                    rf_rdata_a_o;
  logic [31:0]                    rf_rdata_b_o;
  logic [31:0]                    fp_rdata_o;
  logic                           ready_wb_o;
  logic                           instr_done_o;
  logic [31:0]                    pc_wb_o;
  logic                           perf_instr_ret_o;
  logic                           perf_instr_ret_compressed_o;
  logic                           outstanding_load_o;
  logic                           outstanding_store_o;
  logic                           rf_write_wb_o;
  logic                           fp_rf_write_wb_o;
  logic [31:0]                    rf_wdata_fwd_o;

  // Reference state, updated by the writeback rules as each instruction retires
  logic [31:0] int_model [wb_core_pkg::NUM_REGS];
  logic [31:0] fp_model  [wb_core_pkg::NUM_REGS];
  logic [31:0] mem_model [wb_mem_pkg::MEM_WORDS];
  logic [31:0] stored_addrs [$];
  logic [31:0] pc_next;
  integer      seed;
  int          err_cnt = 0;
  int          exp_ret = 0;
  int          exp_cmp = 0;
  int          ret_seen = 0;
  int          cmp_seen = 0;
  int          cycle_cnt = 0;

  wb_subsystem dut_i (
    .clk_i, .rst_ni, .en_wb_i, .instr_type_i, .pc_i, .compressed_i, .perf_count_i,
    .rf_waddr_i, .rf_wdata_i, .rf_we_i, .fp_rf_wdata_i, .fp_rf_we_i, .fp_load_i,
    .lsu_addr_i, .lsu_wdata_i, .rf_raddr_a_i, .rf_raddr_b_i, .fp_raddr_i,
    .rf_rdata_a_o, .rf_rdata_b_o, .fp_rdata_o, .ready_wb_o, .instr_done_o, .pc_wb_o,
    .perf_instr_ret_o, .perf_instr_ret_compressed_o, .outstanding_load_o,
    .outstanding_store_o, .rf_write_wb_o, .fp_rf_write_wb_o, .rf_wdata_fwd_o
  );

  always #10 clk_i = ~clk_i;

  // The run limit lies well above the total length of the directed tests
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: simulation ran %0d cycles without finishing the tests", cycle_cnt);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Pulse totals and the one-write-source rule are watched on every falling edge
  always @(negedge clk_i) begin
    if (rst_ni === 1'b1) begin
      if (perf_instr_ret_o === 1'b1) ret_seen++;
      if (perf_instr_ret_compressed_o === 1'b1) cmp_seen++;
      if (dut_i.lsu_rf_we === 1'b1 &&
          (dut_i.u_wb_stage.alu_we === 1'b1 || dut_i.u_wb_stage.fp_alu_we === 1'b1)) begin
        err_cnt++;
        $display("%0t: load data and an ALU result both wrote a register file", $time);
      end
    end
  end

  task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
    end
  endtask

  // Returns at a falling edge from which the next issue is certain to be accepted
  task automatic wait_ready;
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (ready_wb_o !== 1'b1 && waited < 10) begin
      @(negedge clk_i);
      waited++;
    end
    if (ready_wb_o !== 1'b1) begin
      err_cnt++;
      $display("%0t: ready_wb_o stayed low, no instruction could be issued", $time);
    end
  endtask

  task automatic present_instr(input wb_core_pkg::instr_type_e t, input logic [AW-1:0] waddr,
                               input logic [31:0] wdata, input logic we,
                               input logic [31:0] fdata, input logic fwe, input logic fpl,
                               input logic [31:0] addr, input logic [31:0] sdata,
                               input logic cnt, input logic cmp);
    @(posedge clk_i);
    en_wb_i       <= 1'b1;
    instr_type_i  <= t;
    pc_i          <= pc_next;
    compressed_i  <= cmp;
    perf_count_i  <= cnt;
    rf_waddr_i    <= waddr;
    rf_wdata_i    <= wdata;
    rf_we_i       <= we;
    fp_rf_wdata_i <= fdata;
    fp_rf_we_i    <= fwe;
    fp_load_i     <= fpl;
    lsu_addr_i    <= addr;
    lsu_wdata_i   <= sdata;
    pc_next        = pc_next + (cmp ? 32'd2 : 32'd4);
  endtask

  // The DUT samples the strobe at this edge, so the instruction is taken here
  task automatic drop_enable;
    @(posedge clk_i);
    en_wb_i <= 1'b0;
  endtask

  task automatic expect_retire(input logic cnt, input logic cmp, input logic err);
    if (cnt && !err) exp_ret++;
    if (cnt && cmp && !err) exp_cmp++;
  endtask

  task automatic model_load(input logic [31:0] addr, input logic [AW-1:0] waddr,
                            input logic fpl);
    if (fpl) fp_model[waddr] = mem_model[addr[wb_mem_pkg::MEM_ADDR_W+1:2]];
    else if (waddr != '0) int_model[waddr] = mem_model[addr[wb_mem_pkg::MEM_ADDR_W+1:2]];
  endtask

  task automatic issue_alu(input logic [AW-1:0] waddr, input logic we, input logic fwe,
                           input logic cnt, input logic cmp);
    logic [31:0] data;
    logic [31:0] fdata;
    logic [31:0] pc;
    data  = $random(seed);
    fdata = $random(seed);
    wait_ready();
    pc = pc_next;
    present_instr(wb_core_pkg::OTHER, waddr, data, we, fdata, fwe, 1'b0, '0, '0, cnt, cmp);
    drop_enable();
    // OTHER is done in the first cycle it is held
    @(negedge clk_i);
    compare(instr_done_o, 1'b1, "instr_done_o after ALU accept");
    compare(ready_wb_o, 1'b1, "ready_wb_o while ALU result retires");
    compare(rf_write_wb_o, we, "rf_write_wb_o for ALU write");
    compare(fp_rf_write_wb_o, fwe, "fp_rf_write_wb_o for ALU write");
    compare(rf_wdata_fwd_o, data, "rf_wdata_fwd_o");
    compare(pc_wb_o, pc, "pc_wb_o for ALU instruction");
    compare(perf_instr_ret_o, cnt, "retire pulse for ALU instruction");
    compare(perf_instr_ret_compressed_o, cnt & cmp, "compressed pulse for ALU instruction");
    if (we && waddr != '0) int_model[waddr] = data;
    if (fwe) fp_model[waddr] = fdata;
    expect_retire(cnt, cmp, 1'b0);
  endtask

  task automatic run_mem_op(input logic is_store, input logic [31:0] addr,
                            input logic [31:0] sdata, input logic [AW-1:0] waddr,
                            input logic fpl, input logic cnt, input logic cmp);
    logic        err;
    logic [31:0] pc;
    int          cycles;
    err = (addr[1:0] != 2'b00) || (addr >= wb_mem_pkg::MEM_WORDS * 4);
    wait_ready();
    pc = pc_next;
    present_instr(is_store ? wb_core_pkg::STORE : wb_core_pkg::LOAD, waddr, '0, 1'b0, '0,
                  1'b0, fpl, addr, sdata, cnt, cmp);
    drop_enable();
    cycles = 0;
    while (cycles < 8) begin
      @(negedge clk_i);
      cycles++;
      if (instr_done_o === 1'b1) break;
      compare(ready_wb_o, 1'b0, "ready_wb_o during memory wait");
      compare(is_store ? outstanding_store_o : outstanding_load_o, 1'b1,
              "outstanding flag during memory wait");
      // A held load is a pending write to the file that fp_load selects
      compare(rf_write_wb_o, !is_store && !fpl, "rf_write_wb_o during memory wait");
      compare(fp_rf_write_wb_o, !is_store && fpl, "fp_rf_write_wb_o during memory wait");
    end
    compare(cycles, wb_mem_pkg::LSU_LATENCY, "cycles from accept to instr_done_o");
    compare(ready_wb_o, 1'b1, "ready_wb_o at memory completion");
    compare(pc_wb_o, pc, "pc_wb_o for memory instruction");
    compare(perf_instr_ret_o, cnt & ~err, "retire pulse for memory instruction");
    compare(perf_instr_ret_compressed_o, cnt & cmp & ~err, "compressed pulse for memory op");
    if (!err && is_store) mem_model[addr[wb_mem_pkg::MEM_ADDR_W+1:2]] = sdata;
    if (!err && !is_store) model_load(addr, waddr, fpl);
    expect_retire(cnt, cmp, err);
  endtask

  task automatic issue_load(input logic [31:0] addr, input logic [AW-1:0] waddr,
                            input logic fpl, input logic cnt, input logic cmp);
    run_mem_op(1'b0, addr, '0, waddr, fpl, cnt, cmp);
  endtask

  task automatic issue_store(input logic [31:0] addr, input logic [31:0] data,
                             input logic cnt, input logic cmp);
    run_mem_op(1'b1, addr, data, '0, 1'b0, cnt, cmp);
  endtask

  // Load, then an ALU instruction offered in the cycle the load completes
  task automatic load_then_alu(input logic [31:0] addr, input logic [AW-1:0] l_waddr,
                               input logic fpl, input logic cnt, input logic cmp);
    logic [AW-1:0] a_waddr;
    logic [31:0]   data;
    logic [31:0]   load_pc;
    logic [31:0]   alu_pc;
    a_waddr = {1'b1, l_waddr[AW-2:0]};
    data    = $random(seed);
    wait_ready();
    load_pc = pc_next;
    present_instr(wb_core_pkg::LOAD, l_waddr, '0, 1'b0, '0, 1'b0, fpl, addr, '0, cnt, cmp);
    drop_enable();
    repeat (wb_mem_pkg::LSU_LATENCY - 2) @(posedge clk_i);
    alu_pc = pc_next;
    present_instr(wb_core_pkg::OTHER, a_waddr, data, 1'b1, '0, 1'b0, 1'b0, '0, '0, cnt, cmp);
    @(negedge clk_i);
    compare(instr_done_o, 1'b1, "load completion under back-to-back issue");
    compare(ready_wb_o, 1'b1, "ready_wb_o in load completion cycle");
    compare(pc_wb_o, load_pc, "pc_wb_o of completing load");
    drop_enable();
    @(negedge clk_i);
    compare(instr_done_o, 1'b1, "back-to-back ALU instruction done");
    compare(pc_wb_o, alu_pc, "pc_wb_o of back-to-back ALU instruction");
    compare(rf_wdata_fwd_o, data, "rf_wdata_fwd_o of back-to-back ALU instruction");
    compare(outstanding_load_o, 1'b0, "outstanding_load_o after load retired");
    model_load(addr, l_waddr, fpl);
    int_model[a_waddr] = data;
    expect_retire(cnt, cmp, 1'b0);
    expect_retire(cnt, cmp, 1'b0);
  endtask

  task automatic readback_regs(input int idx);
    @(posedge clk_i);
    rf_raddr_a_i <= AW'(idx);
    rf_raddr_b_i <= AW'(idx);
    fp_raddr_i   <= AW'(idx);
    @(negedge clk_i);
    compare(rf_rdata_a_o, int_model[idx], $sformatf("integer x%0d on port a", idx));
    compare(rf_rdata_b_o, int_model[idx], $sformatf("integer x%0d on port b", idx));
    compare(fp_rdata_o, fp_model[idx], $sformatf("FP f%0d", idx));
  endtask

  task automatic reset_state;
    @(negedge clk_i);
    compare(ready_wb_o, 1'b1, "ready_wb_o after reset");
    compare(instr_done_o, 1'b0, "instr_done_o after reset");
    compare(outstanding_load_o, 1'b0, "outstanding_load_o after reset");
    compare(outstanding_store_o, 1'b0, "outstanding_store_o after reset");
    compare(rf_write_wb_o, 1'b0, "rf_write_wb_o after reset");
    compare(fp_rf_write_wb_o, 1'b0, "fp_rf_write_wb_o after reset");
    compare(perf_instr_ret_o, 1'b0, "perf_instr_ret_o after reset");
    compare(perf_instr_ret_compressed_o, 1'b0, "perf_instr_ret_compressed_o after reset");
  endtask

  // x0 is written too and must still read zero
  task automatic int_alu_writes;
    for (int i = 0; i < wb_core_pkg::NUM_REGS; i++) issue_alu(AW'(i), 1'b1, 1'b0, 1'b1, 1'b0);
  endtask

  // f0 is an ordinary register, and the integer file must not move
  task automatic fp_alu_writes;
    for (int i = 0; i < wb_core_pkg::NUM_REGS; i++) issue_alu(AW'(i), 1'b0, 1'b1, 1'b1, 1'b1);
    for (int i = 0; i < wb_core_pkg::NUM_REGS; i++) readback_regs(i);
  endtask

  // The error test relies on word 0 being among the stored words
  task automatic store_load_pairs;
    logic [31:0] addr;
    for (int k = 0; k < 4; k++) begin
      addr = (k * 16 + (k == 0 ? 0 : $unsigned($random(seed)) % 16)) * 4;
      stored_addrs.push_back(addr);
      issue_store(addr, $random(seed), 1'b1, 1'b0);
    end
    for (int k = 0; k < 4; k++) begin
      issue_load(stored_addrs[k], AW'(k + 1), 1'b0, 1'b1, 1'b0);
      readback_regs(k + 1);
      issue_load(stored_addrs[k], AW'(k + 8), 1'b1, 1'b1, 1'b1);
      readback_regs(k + 8);
    end
  endtask

  task automatic load_errors;
    issue_load(32'h0000_0102, AW'(5), 1'b0, 1'b1, 1'b0);
    readback_regs(5);
    issue_load(32'h0000_0100, AW'(5), 1'b1, 1'b1, 1'b0);
    readback_regs(5);
    issue_load(32'h8000_0000, AW'(5), 1'b0, 1'b1, 1'b1);
    readback_regs(5);
    // 0x100 aliases word 0 in the low address bits, so a leaked store would show there
    issue_store(32'h0000_0100, $random(seed), 1'b1, 1'b0);
    issue_load(32'h0000_0000, AW'(6), 1'b0, 1'b1, 1'b0);
    readback_regs(6);
  endtask

  task automatic retire_mix;
    int          sel;
    logic        cnt;
    logic        cmp;
    logic [31:0] addr;
    for (int n = 0; n < 24; n++) begin
      sel  = $unsigned($random(seed)) % 3;
      cnt  = $random(seed);
      cmp  = $random(seed);
      addr = stored_addrs[$unsigned($random(seed)) % stored_addrs.size()];
      case (sel)
        0: issue_alu(AW'(1 + $unsigned($random(seed)) % 31), 1'b1, $random(seed), cnt, cmp);
        1: issue_load(addr, AW'(1 + $unsigned($random(seed)) % 31), $random(seed), cnt, cmp);
        default: load_then_alu(addr, AW'(1 + $unsigned($random(seed)) % 15), $random(seed),
                               cnt, cmp);
      endcase
    end
    for (int i = 0; i < wb_core_pkg::NUM_REGS; i++) readback_regs(i);
  endtask

  initial begin
    rst_ni        = 1'b0;
    en_wb_i       = 1'b0;
    instr_type_i  = wb_core_pkg::OTHER;
    pc_i          = '0;
    compressed_i  = 1'b0;
    perf_count_i  = 1'b0;
    rf_waddr_i    = '0;
    rf_wdata_i    = '0;
    rf_we_i       = 1'b0;
    fp_rf_wdata_i = '0;
    fp_rf_we_i    = 1'b0;
    fp_load_i     = 1'b0;
    lsu_addr_i    = '0;
    lsu_wdata_i   = '0;
    rf_raddr_a_i  = '0;
    rf_raddr_b_i  = '0;
    fp_raddr_i    = '0;
    seed          = 32'h6c;
    pc_next       = 32'h0000_1000;
    int_model[0]  = '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    reset_state();
    int_alu_writes();
    fp_alu_writes();
    store_load_pairs();
    load_errors();
    retire_mix();
    repeat (2) @(negedge clk_i);
    compare(ret_seen, exp_ret, "retire pulse total");
    compare(cmp_seen, exp_cmp, "compressed retire pulse total");
    $display("Errors: %0d, retire pulses: %0d, compressed pulses: %0d",
             err_cnt, ret_seen, cmp_seen);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: wb_subsystem.f
source/wb_core_pkg.sv
source/wb_mem_pkg.sv
source/wb_reg_file.sv
source/wb_lsu.sv
source/wb_stage.sv
source/wb_subsystem.sv
tests/tb_wb_subsystem.sv
